//--- build.f
+incdir+include
rtl/cacheDirPkg.sv
rtl/lruAgeSet.sv
rtl/setAssociativeLru.sv
rtl/tagDirectory.sv
rtl/directoryController.sv
rtl/apbCommandPort.sv
rtl/cacheDirectoryTop.sv
dv/tbClockGen.sv
dv/cacheDirectoryTb.sv

//--- dv/cacheDirectoryTb.sv
`timescale 1ns/1ns
`include "apbMap.svh"

module cacheDirectoryTb;
	import cacheDirPkg::*;

	localparam int indexWidth = 3;
	localparam int wayCountLog2 = 2;
	localparam int tagWidth = 8;
	localparam int setCount = 1 << indexWidth;
	localparam int wayCount = 1 << wayCountLog2;
	// about 300 commands at 10 cycles each, plus margin
	localparam int timeoutCycles = 4000;

	logic clock;
	logic rstN;
	apbReq_t apbIn;
	apbRsp_t apbOut;

	int errorCount;
	int checkCount;
	int cycleCount;
	int expHits;
	int expMisses;
	string currentTest;

	// reference state of tags, valid bits and ages
	logic [tagWidth-1:0] modelTag [setCount][wayCount];
	bit modelValid [setCount][wayCount];
	int modelAge [setCount][wayCount];

	tbClockGen clockGen (
		.clock(clock),
		.rstN(rstN)
	);

	cacheDirectoryTop #(
		.indexWidth(indexWidth),
		.wayCountLog2(wayCountLog2),
		.tagWidth(tagWidth)
	) u_dut (
		.clock(clock),
		.rstN(rstN),
		.apbIn(apbIn),
		.apbOut(apbOut)
	);

	task automatic reportMismatch(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		errorCount++;
		$display("Fail %s %s: expected 0x%08h, actual 0x%08h", currentTest, what, expected,
			actual);
	endtask

	// stayOnBus lets the next transfer start its setup phase right away
	task automatic apbTransfer(input logic write, input logic [3:0] addr,
			input logic [31:0] wdata, input bit stayOnBus, output logic [31:0] rdata,
			output int stalls);
		bit done;
		stalls = 0;
		done = 1'b0;
		rdata = '0;
		@(negedge clock);
		apbIn.psel = 1'b1;
		apbIn.penable = 1'b0;
		apbIn.pwrite = write;
		apbIn.paddr = addr;
		apbIn.pwdata = wdata;
		@(negedge clock);
		apbIn.penable = 1'b1;
		while (!done) begin
			@(posedge clock);
			if (apbOut.pready) begin
				done = 1'b1;
				rdata = apbOut.prdata;
				checkCount++;
				if (apbOut.pslverr) begin
					reportMismatch("pslverr", 32'h0, 32'(apbOut.pslverr));
				end
			end else begin
				stalls++;
			end
		end
		if (!stayOnBus) begin
			@(negedge clock);
			apbIn = '0;
		end
	endtask

	task automatic apbWrite(input logic [3:0] addr, input logic [31:0] wdata);
		logic [31:0] unused;
		int stalls;
		apbTransfer(1'b1, addr, wdata, 1'b0, unused, stalls);
	endtask

	task automatic apbRead(input logic [3:0] addr, output logic [31:0] rdata);
		int stalls;
		apbTransfer(1'b0, addr, '0, 1'b0, rdata, stalls);
	endtask

	function automatic logic [31:0] commandWord(input dirOp_t op, input int index,
			input int tag);
		logic [31:0] word;
		word = '0;
		word[`CMD_OP_BIT] = op;
		word[`CMD_INDEX_LSB +: indexWidth] = index[indexWidth-1:0];
		word[`CMD_TAG_LSB +: tagWidth] = tag[tagWidth-1:0];
		return word;
	endfunction

	function automatic logic [31:0] expectedResult(input bit hit, input int way);
		logic [31:0] word;
		word = '0;
		word[`RES_VALID_BIT] = 1'b1;
		word[`RES_HIT_BIT] = hit;
		word[`RES_WAY_LSB +: wayCountLog2] = way[wayCountLog2-1:0];
		return word;
	endfunction

	task automatic resetModel();
		for (int s = 0; s < setCount; s++) begin
			for (int w = 0; w < wayCount; w++) begin
				modelTag[s][w] = '0;
				modelValid[s][w] = 1'b0;
				modelAge[s][w] = wayCount - 1 - w;
			end
		end
	endtask

	function automatic int findWay(input int index, input int tag);
		for (int w = 0; w < wayCount; w++) begin
			if (modelValid[index][w] && modelTag[index][w] == tag[tagWidth-1:0]) begin
				return w;
			end
		end
		return -1;
	endfunction

	function automatic int oldestWay(input int index);
		int way;
		way = 0;
		for (int w = 0; w < wayCount; w++) begin
			if (modelAge[index][w] == wayCount - 1) begin
				way = w;
			end
		end
		return way;
	endfunction

	// touched way becomes youngest, the younger ones age by one
	task automatic ageOnAccess(input int index, input int way);
		int touched;
		touched = modelAge[index][way];
		for (int w = 0; w < wayCount; w++) begin
			if (w == way) begin
				modelAge[index][w] = 0;
			end else if (modelAge[index][w] < touched) begin
				modelAge[index][w]++;
			end
		end
	endtask

	task automatic ageOnInvalidate(input int index, input int way);
		int touched;
		touched = modelAge[index][way];
		for (int w = 0; w < wayCount; w++) begin
			if (w == way) begin
				modelAge[index][w] = wayCount - 1;
			end else if (modelAge[index][w] > touched) begin
				modelAge[index][w]--;
			end
		end
	endtask

	task automatic applyToModel(input dirOp_t op, input int index, input int tag,
			output bit hit, output int way);
		way = findWay(index, tag);
		hit = (way >= 0);
		if (!hit) begin
			way = oldestWay(index);
		end
		if (op == opAccess) begin
			if (!hit) begin
				modelTag[index][way] = tag[tagWidth-1:0];
				modelValid[index][way] = 1'b1;
			end
			ageOnAccess(index, way);
		end else if (hit) begin
			modelValid[index][way] = 1'b0;
			ageOnInvalidate(index, way);
		end
		if (hit) begin
			expHits++;
		end else begin
			expMisses++;
		end
	endtask

	task automatic runCommand(input dirOp_t op, input int index, input int tag,
			output bit actHit, output int actWay);
		bit expHit;
		int expWay;
		logic [31:0] expWord;
		logic [31:0] careMask;
		logic [31:0] rdata;
		applyToModel(op, index, tag, expHit, expWay);
		apbWrite(`CMD_ADDR, commandWord(op, index, tag));
		apbRead(`RESULT_ADDR, rdata);
		expWord = expectedResult(expHit, expWay);
		careMask = '1;
		// way field carries no meaning for a missed invalidate
		if (op == opInvalidate && !expHit) begin
			careMask = '0;
			careMask[`RES_VALID_BIT] = 1'b1;
			careMask[`RES_HIT_BIT] = 1'b1;
		end
		checkCount++;
		if ((rdata & careMask) != (expWord & careMask)) begin
			reportMismatch("result", expWord, rdata);
		end
		actHit = rdata[`RES_HIT_BIT];
		actWay = rdata[`RES_WAY_LSB +: wayCountLog2];
	endtask

	task automatic checkCounters();
		logic [31:0] rdata;
		apbRead(`HITS_ADDR, rdata);
		checkCount++;
		if (rdata != expHits) begin
			reportMismatch("hit counter", expHits, rdata);
		end
		apbRead(`MISSES_ADDR, rdata);
		checkCount++;
		if (rdata != expMisses) begin
			reportMismatch("miss counter", expMisses, rdata);
		end
	endtask

	task automatic testResetState();
		logic [31:0] rdata;
		bit hit;
		int way;
		currentTest = "testResetState";
		apbRead(`RESULT_ADDR, rdata);
		checkCount++;
		if (rdata != 32'h0) begin
			reportMismatch("result register", 32'h0, rdata);
		end
		checkCounters();
		for (int s = 0; s < setCount; s++) begin
			runCommand(opAccess, s, 8'hA0 + s, hit, way);
			checkCount++;
			if (hit) begin
				reportMismatch("hit in empty set", 0, hit);
			end
			checkCount++;
			if (way != 0) begin
				reportMismatch("first way", 0, way);
			end
		end
	endtask

	task automatic testFillAndHit();
		logic [31:0] hitsBefore;
		logic [31:0] hitsAfter;
		bit hit;
		int way;
		currentTest = "testFillAndHit";
		// dropping the earlier line makes way 0 the oldest again
		runCommand(opInvalidate, 5, 8'hA5, hit, way);
		for (int i = 0; i < wayCount; i++) begin
			runCommand(opAccess, 5, 8'h50 + i, hit, way);
			checkCount++;
			if (way != i) begin
				reportMismatch("fill way", i, way);
			end
		end
		checkCounters();
		hitsBefore = expHits;
		for (int i = 0; i < wayCount; i++) begin
			runCommand(opAccess, 5, 8'h50 + i, hit, way);
			checkCount++;
			if (!hit || way != i) begin
				reportMismatch("repeat hit way", i, way);
			end
		end
		apbRead(`HITS_ADDR, hitsAfter);
		checkCount++;
		if (hitsAfter != hitsBefore + wayCount) begin
			reportMismatch("hit counter growth", hitsBefore + wayCount, hitsAfter);
		end
	endtask

	task automatic testLruVictim();
		int touchTags [4] = '{8'h22, 8'hA2, 8'h23, 8'h21};
		bit hit;
		int way;
		int victim;
		int evicted;
		currentTest = "testLruVictim";
		for (int i = 1; i < wayCount; i++) begin
			runCommand(opAccess, 2, 8'h20 + i, hit, way);
		end
		foreach (touchTags[i]) begin
			runCommand(opAccess, 2, touchTags[i], hit, way);
		end
		victim = oldestWay(2);
		evicted = modelTag[2][victim];
		runCommand(opAccess, 2, 8'h2F, hit, way);
		checkCount++;
		if (hit || way != victim) begin
			reportMismatch("victim way", victim, way);
		end
		runCommand(opAccess, 2, evicted, hit, way);
		checkCount++;
		if (hit) begin
			reportMismatch("evicted tag still present", 0, hit);
		end
	endtask

	task automatic testInvalidate();
		bit hit;
		int way;
		int presentWay;
		currentTest = "testInvalidate";
		presentWay = findWay(3, 8'hA3);
		runCommand(opInvalidate, 3, 8'hA3, hit, way);
		checkCount++;
		if (!hit || way != presentWay) begin
			reportMismatch("invalidate way", presentWay, way);
		end
		runCommand(opAccess, 3, 8'hA3, hit, way);
		checkCount++;
		if (hit || way != presentWay) begin
			reportMismatch("refill way", presentWay, way);
		end
		runCommand(opInvalidate, 3, 8'h77, hit, way);
		checkCount++;
		if (hit) begin
			reportMismatch("absent tag invalidate", 0, hit);
		end
	endtask

	task automatic testSetIsolation();
		logic [tagWidth-1:0] savedTags [wayCount];
		bit hit;
		int way;
		int savedVictim;
		currentTest = "testSetIsolation";
		for (int i = 1; i < wayCount; i++) begin
			runCommand(opAccess, 7, 8'h70 + i, hit, way);
		end
		savedVictim = oldestWay(7);
		savedTags = modelTag[7];
		// mixed traffic in the neighbouring set
		for (int i = 0; i < 16; i++) begin
			runCommand((i % 5 == 4) ? opInvalidate : opAccess, 6, 8'h60 + (i % 6), hit, way);
		end
		runCommand(opAccess, 7, 8'h7F, hit, way);
		checkCount++;
		if (hit || way != savedVictim) begin
			reportMismatch("victim of quiet set", savedVictim, way);
		end
		for (int w = 0; w < wayCount; w++) begin
			if (w != savedVictim) begin
				runCommand(opAccess, 7, savedTags[w], hit, way);
				checkCount++;
				if (!hit || way != w) begin
					reportMismatch("hit way of quiet set", w, way);
				end
			end
		end
	endtask

	task automatic testBackPressureRandom();
		logic [31:0] unused;
		logic [31:0] rdata;
		int stalls;
		int expStalls;
		bit hit;
		int way;
		dirOp_t op;
		currentTest = "testBackPressureRandom";
		// three command writes with no idle cycle between them
		for (int i = 0; i < 3; i++) begin
			applyToModel(opAccess, 4, 8'h40 + i, hit, way);
			apbTransfer(1'b1, `CMD_ADDR, commandWord(opAccess, 4, 8'h40 + i), i < 2, unused,
				stalls);
			// the first write finds the sequencer idle
			expStalls = (i == 0) ? 0 : 1;
			checkCount++;
			if (stalls != expStalls) begin
				reportMismatch("stall cycles", expStalls, stalls);
			end
		end
		apbRead(`RESULT_ADDR, rdata);
		checkCount++;
		if (rdata != expectedResult(hit, way)) begin
			reportMismatch("result after burst", expectedResult(hit, way), rdata);
		end
		checkCounters();
		for (int i = 0; i < 200; i++) begin
			op = ($urandom_range(3) == 0) ? opInvalidate : opAccess;
			runCommand(op, $urandom_range(setCount - 1), $urandom_range(11), hit, way);
			if (i % 25 == 24) begin
				checkCounters();
			end
		end
	endtask

	initial begin
		cycleCount = 0;
		while (cycleCount < timeoutCycles) begin
			@(posedge clock);
			cycleCount++;
		end
		$display("run stopped after %0d cycles before the tests finished", timeoutCycles);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		errorCount = 0;
		checkCount = 0;
		expHits = 0;
		expMisses = 0;
		currentTest = "";
		apbIn = '0;
		void'($urandom(4));
		resetModel();
		@(posedge rstN);
		testResetState();
		testFillAndHit();
		testLruVictim();
		testInvalidate();
		testSetIsolation();
		testBackPressureRandom();
		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule : cacheDirectoryTb

//--- dv/tbClockGen.sv
`timescale 1ns/1ns

module tbClockGen #(
	parameter int halfPeriod = 2,
	parameter int resetCycles = 8
) (
	output logic clock,
	output logic rstN
);

	initial begin
		clock = 1'b0;
		forever #halfPeriod clock = ~clock;
	end

	// released on a falling edge, away from the active edge
	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clock);
		@(negedge clock);
		rstN = 1'b1;
	end

endmodule : tbClockGen

//--- rtl/cacheDirectoryTop.sv
`timescale 1ns/1ns

module cacheDirectoryTop #(
	parameter int indexWidth = 3,
	parameter int wayCountLog2 = 2,
	parameter int tagWidth = 8
) (
	input logic clock,
	input logic rstN,
	input cacheDirPkg::apbReq_t apbIn,
	output cacheDirPkg::apbRsp_t apbOut
);
	import cacheDirPkg::*;

	// command path
	logic cmdValid;
	dirOp_t cmdOp;
	logic [indexWidth-1:0] cmdIndex;
	logic [tagWidth-1:0] cmdTag;
	logic busy;
	logic resultValid;
	logic resultHit;
	logic [wayCountLog2-1:0] resultWay;

	// directory and lru path
	logic [indexWidth-1:0] lookupIndex;
	logic [tagWidth-1:0] lookupTag;
	logic hit;
	logic [wayCountLog2-1:0] hitWay;
	logic tagWrite;
	logic [wayCountLog2-1:0] tagWriteWay;
	logic tagWriteValid;
	lruCtrl_t lruCtrl;
	logic [wayCountLog2-1:0] victimWay;

	apbCommandPort #(
		.indexWidth(indexWidth),
		.wayCountLog2(wayCountLog2),
		.tagWidth(tagWidth)
	) uPort (
		.clock(clock),
		.rstN(rstN),
		.apbIn(apbIn),
		.busy(busy),
		.resultValid(resultValid),
		.resultHit(resultHit),
		.resultWay(resultWay),
		.apbOut(apbOut),
		.cmdValid(cmdValid),
		.cmdOp(cmdOp),
		.cmdIndex(cmdIndex),
		.cmdTag(cmdTag)
	);

	directoryController #(
		.indexWidth(indexWidth),
		.wayCountLog2(wayCountLog2),
		.tagWidth(tagWidth)
	) uCtrl (
		.clock(clock),
		.rstN(rstN),
		.cmdValid(cmdValid),
		.cmdOp(cmdOp),
		.cmdIndex(cmdIndex),
		.cmdTag(cmdTag),
		.hit(hit),
		.hitWay(hitWay),
		.victimWay(victimWay),
		.busy(busy),
		.lookupIndex(lookupIndex),
		.lookupTag(lookupTag),
		.tagWrite(tagWrite),
		.tagWriteWay(tagWriteWay),
		.tagWriteValid(tagWriteValid),
		.lruCtrl(lruCtrl),
		.resultValid(resultValid),
		.resultHit(resultHit),
		.resultWay(resultWay)
	);

	// the latched tag is also the tag to store
	tagDirectory #(
		.indexWidth(indexWidth),
		.wayCountLog2(wayCountLog2),
		.tagWidth(tagWidth)
	) uTags (
		.clock(clock),
		.rstN(rstN),
		.lookupIndex(lookupIndex),
		.lookupTag(lookupTag),
		.writeEnable(tagWrite),
		.writeWay(tagWriteWay),
		.writeTag(lookupTag),
		.writeValid(tagWriteValid),
		.hit(hit),
		.hitWay(hitWay)
	);

	setAssociativeLru #(
		.indexWidth(indexWidth),
		.wayCountLog2(wayCountLog2)
	) uLru (
		.clock(clock),
		.rstN(rstN),
		.index(lookupIndex),
		.ctrl(lruCtrl),
		.victimWay(victimWay)
	);

endmodule : cacheDirectoryTop

//--- rtl/apbCommandPort.sv
`timescale 1ns/1ns
`include "apbMap.svh"

module apbCommandPort #(
	parameter int indexWidth = 3,
	parameter int wayCountLog2 = 2,
	parameter int tagWidth = 8
) (
	input logic clock,
	input logic rstN,
	input cacheDirPkg::apbReq_t apbIn,
	input logic busy,
	input logic resultValid,
	input logic resultHit,
	input logic [wayCountLog2-1:0] resultWay,
	output cacheDirPkg::apbRsp_t apbOut,
	output logic cmdValid,
	output cacheDirPkg::dirOp_t cmdOp,
	output logic [indexWidth-1:0] cmdIndex,
	output logic [tagWidth-1:0] cmdTag
);
	import cacheDirPkg::*;

	logic accessPhase;
	logic cmdSelected;
	logic ready;
	logic [31:0] cmdWord;
	logic [31:0] resultReg;
	logic [31:0] resultNext;
	logic [31:0] hitCount;
	logic [31:0] missCount;
	logic [31:0] readData;

	assign accessPhase = apbIn.psel && apbIn.penable;
	assign cmdSelected = (apbIn.paddr == `CMD_ADDR);

	// the command register waits for the sequencer to go idle
	assign ready = !(accessPhase && cmdSelected && busy);

	assign cmdValid = accessPhase && apbIn.pwrite && cmdSelected && ready;
	assign cmdTag = apbIn.pwdata[`CMD_TAG_LSB +: tagWidth];
	assign cmdIndex = apbIn.pwdata[`CMD_INDEX_LSB +: indexWidth];
	assign cmdOp = dirOp_t'(apbIn.pwdata[`CMD_OP_BIT]);

	always_comb begin
		resultNext = '0;
		resultNext[`RES_VALID_BIT] = 1'b1;
		resultNext[`RES_HIT_BIT] = resultHit;
		resultNext[`RES_WAY_LSB +: wayCountLog2] = resultWay;
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			cmdWord <= '0;
			resultReg <= '0;
			hitCount <= '0;
			missCount <= '0;
		end else begin
			if (cmdValid) begin
				cmdWord <= apbIn.pwdata;
			end
			// invalidates count here as well
			if (resultValid) begin
				resultReg <= resultNext;
				if (resultHit) begin
					hitCount <= hitCount + 1'b1;
				end else begin
					missCount <= missCount + 1'b1;
				end
			end
		end
	end

	always_comb begin
		case (apbIn.paddr)
			`CMD_ADDR: readData = cmdWord;
			`RESULT_ADDR: readData = resultReg;
			`HITS_ADDR: readData = hitCount;
			`MISSES_ADDR: readData = missCount;
			default: readData = '0;
		endcase
	end

	always_comb begin
		apbOut.prdata = readData;
		apbOut.pready = ready;
		apbOut.pslverr = 1'b0;
	end

endmodule : apbCommandPort

//--- rtl/directoryController.sv
`timescale 1ns/1ns

module directoryController #(
	parameter int indexWidth = 3,
	parameter int wayCountLog2 = 2,
	parameter int tagWidth = 8
) (
	input logic clock,
	input logic rstN,
	input logic cmdValid,
	input cacheDirPkg::dirOp_t cmdOp,
	input logic [indexWidth-1:0] cmdIndex,
	input logic [tagWidth-1:0] cmdTag,
	input logic hit,
	input logic [wayCountLog2-1:0] hitWay,
	input logic [wayCountLog2-1:0] victimWay,
	output logic busy,
	output logic [indexWidth-1:0] lookupIndex,
	output logic [tagWidth-1:0] lookupTag,
	output logic tagWrite,
	output logic [wayCountLog2-1:0] tagWriteWay,
	output logic tagWriteValid,
	output cacheDirPkg::lruCtrl_t lruCtrl,
	output logic resultValid,
	output logic resultHit,
	output logic [wayCountLog2-1:0] resultWay
);
	import cacheDirPkg::*;

	typedef enum logic [1:0] {
		stateIdle,
		stateLookup,
		stateUpdate
	} state_t;

	state_t state;
	dirOp_t op;
	logic [indexWidth-1:0] index;
	logic [tagWidth-1:0] tag;
	logic wasHit;
	logic [wayCountLog2-1:0] targetWay;
	logic inUpdate;
	logic isAccess;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			state <= stateIdle;
		end else begin
			case (state)
				stateIdle: if (cmdValid) state <= stateLookup;
				stateLookup: state <= stateUpdate;
				default: state <= stateIdle;
			endcase
		end
	end

	// command latched on accept, lookup outcome captured one cycle later
	always_ff @(posedge clock) begin
		if (state == stateIdle && cmdValid) begin
			op <= cmdOp;
			index <= cmdIndex;
			tag <= cmdTag;
		end
		if (state == stateLookup) begin
			wasHit <= hit;
			// a miss on access evicts the oldest way
			targetWay <= hit ? hitWay : victimWay;
		end
	end

	assign busy = (state != stateIdle);
	assign inUpdate = (state == stateUpdate);
	assign isAccess = (op == opAccess);

	// index and tag hold steady through lookup and update
	assign lookupIndex = index;
	assign lookupTag = tag;

	// access miss fills, invalidate hit clears, nothing else writes
	assign tagWrite = inUpdate && (isAccess ? !wasHit : wasHit);
	assign tagWriteWay = targetWay;
	assign tagWriteValid = isAccess;

	always_comb begin
		lruCtrl.accessEnable = inUpdate && isAccess;
		lruCtrl.invalidateEnable = inUpdate && !isAccess && wasHit;
		lruCtrl.lastAccessedWay = maxWayWidth'(targetWay);
	end

	assign resultValid = inUpdate;
	assign resultHit = wasHit;
	assign resultWay = targetWay;

endmodule : directoryController

//--- rtl/tagDirectory.sv
`timescale 1ns/1ns

module tagDirectory #(
	parameter int indexWidth = 3,
	parameter int wayCountLog2 = 2,
	parameter int tagWidth = 8
) (
	input logic clock,
	input logic rstN,
	input logic [indexWidth-1:0] lookupIndex,
	input logic [tagWidth-1:0] lookupTag,
	input logic writeEnable,
	input logic [wayCountLog2-1:0] writeWay,
	input logic [tagWidth-1:0] writeTag,
	input logic writeValid,
	output logic hit,
	output logic [wayCountLog2-1:0] hitWay
);

	localparam int setCount = 1 << indexWidth;
	localparam int wayCount = 1 << wayCountLog2;

	logic [tagWidth-1:0] tags [setCount][wayCount];
	logic [wayCount-1:0] validBits [setCount];
	logic [wayCount-1:0] wayMatch;

	always_ff @(posedge clock) begin
		if (writeEnable) begin
			tags[lookupIndex][writeWay] <= writeTag;
		end
	end

	// every way starts invalid
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int s = 0; s < setCount; s++) begin
				validBits[s] <= '0;
			end
		end else if (writeEnable) begin
			validBits[lookupIndex][writeWay] <= writeValid;
		end
	end

	// all ways of the set compared at once
	always_comb begin
		for (int w = 0; w < wayCount; w++) begin
			wayMatch[w] = validBits[lookupIndex][w] && (tags[lookupIndex][w] == lookupTag);
		end
	end

	// a tag lives in one way at most, so a plain encoder is enough
	always_comb begin
		hit = 1'b0;
		hitWay = '0;
		for (int w = 0; w < wayCount; w++) begin
			if (wayMatch[w]) begin
				hit = 1'b1;
				hitWay = wayCountLog2'(w);
			end
		end
	end

endmodule : tagDirectory

//--- rtl/setAssociativeLru.sv
`timescale 1ns/1ns

module setAssociativeLru #(
	parameter int indexWidth = 3,
	parameter int wayCountLog2 = 2
) (
	input logic clock,
	input logic rstN,
	input logic [indexWidth-1:0] index,
	input cacheDirPkg::lruCtrl_t ctrl,
	output logic [wayCountLog2-1:0] victimWay
);
	import cacheDirPkg::*;

	localparam int setCount = 1 << indexWidth;

	lruCtrl_t setCtrl [setCount];
	logic [wayCountLog2-1:0] setVictims [setCount];

	// the way goes to every set, the enables only to the indexed one
	always_comb begin
		for (int i = 0; i < setCount; i++) begin
			setCtrl[i].lastAccessedWay = ctrl.lastAccessedWay;
			if (index == i) begin
				setCtrl[i].accessEnable = ctrl.accessEnable;
				setCtrl[i].invalidateEnable = ctrl.invalidateEnable;
			end else begin
				setCtrl[i].accessEnable = 1'b0;
				setCtrl[i].invalidateEnable = 1'b0;
			end
		end
	end

	for (genvar i = 0; i < setCount; i++) begin : gSet
		lruAgeSet #(
			.wayCountLog2(wayCountLog2)
		) uLru (
			.clock(clock),
			.rstN(rstN),
			.ctrl(setCtrl[i]),
			.victimWay(setVictims[i])
		);
	end

	// victim of the selected set
	always_comb begin
		victimWay = '0;
		for (int i = 0; i < setCount; i++) begin
			if (index == i) begin
				victimWay = setVictims[i];
			end
		end
	end

endmodule : setAssociativeLru

//--- rtl/lruAgeSet.sv
`timescale 1ns/1ns

module lruAgeSet #(
	parameter int wayCountLog2 = 2
) (
	input logic clock,
	input logic rstN,
	input cacheDirPkg::lruCtrl_t ctrl,
	output logic [wayCountLog2-1:0] victimWay
);

	localparam int wayCount = 1 << wayCountLog2;
	// age of the least recently used way
	localparam logic [wayCountLog2-1:0] oldestAge = '1;

	// age 0 is the most recently used way
	logic [wayCountLog2-1:0] ages [wayCount];
	logic [wayCountLog2-1:0] touchedWay;
	logic [wayCountLog2-1:0] touchedAge;

	assign touchedWay = ctrl.lastAccessedWay[wayCountLog2-1:0];
	assign touchedAge = ages[touchedWay];

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			// way 0 starts as the oldest
			for (int w = 0; w < wayCount; w++) begin
				ages[w] <= wayCountLog2'(wayCount - 1 - w);
			end
		end else if (ctrl.accessEnable) begin
			for (int w = 0; w < wayCount; w++) begin
				if (w == touchedWay) begin
					ages[w] <= '0;
				end else if (ages[w] < touchedAge) begin
					ages[w] <= ages[w] + 1'b1;
				end
			end
		end else if (ctrl.invalidateEnable) begin
			// invalidated way drops to the back of the queue
			for (int w = 0; w < wayCount; w++) begin
				if (w == touchedWay) begin
					ages[w] <= oldestAge;
				end else if (ages[w] > touchedAge) begin
					ages[w] <= ages[w] - 1'b1;
				end
			end
		end
	end

	// ages stay a permutation, so exactly one way matches
	always_comb begin
		victimWay = '0;
		for (int w = 0; w < wayCount; w++) begin
			if (ages[w] == oldestAge) begin
				victimWay = wayCountLog2'(w);
			end
		end
	end

endmodule : lruAgeSet

//--- rtl/cacheDirPkg.sv
package cacheDirPkg;

	// widest way number any directory instance may use
	localparam int maxWayWidth = 4;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [3:0] paddr;
		logic [31:0] pwdata;
	} apbReq_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic pready;
		logic pslverr;
	} apbRsp_t;

	typedef enum logic {
		opAccess = 1'b0,
		opInvalidate = 1'b1
	} dirOp_t;

	// one update per cycle at most, so only one enable is set
	typedef struct packed {
		logic accessEnable;
		logic invalidateEnable;
		logic [maxWayWidth-1:0] lastAccessedWay;
	} lruCtrl_t;

endpackage : cacheDirPkg

//--- include/apbMap.svh
`ifndef APB_MAP_SVH
`define APB_MAP_SVH

// register offsets on the APB
`define CMD_ADDR 4'h0
`define RESULT_ADDR 4'h4
`define HITS_ADDR 4'h8
`define MISSES_ADDR 4'hC

// command word layout
`define CMD_TAG_LSB 0
`define CMD_INDEX_LSB 16
`define CMD_OP_BIT 31

// result word layout
`define RES_VALID_BIT 31
`define RES_HIT_BIT 30
`define RES_WAY_LSB 0

`endif
